// ==== project.f ====
hw/rv_front_pkg.sv
hw/fetch_align_fsm.sv
hw/pc_counter.sv
hw/rvc_decode.sv
hw/rv32_decode.sv
hw/decode_out_reg.sv
hw/rv_front_top.sv
testbench/tb_rv_front.sv

// ==== testbench/tb_rv_front.sv ====
`timescale 1ns/1ps

module tb_rv_front;
  import rv_front_pkg::*;

  localparam addr_t RESET_VECTOR = 32'h0000_1000;
  localparam int    N_WORDS = 18;
  localparam int    RESET_CYCLES = 10;
  localparam int    CYCLE_LIMIT = 20 * N_WORDS + RESET_CYCLES;
  localparam int    TAIL_CYCLES = 8;  // Watch for extra beats after the last one

  logic      clock, rst, fetch_valid, fetch_req, out_valid, compressed;
  instr_t    fetch_word;
  addr_t     pc;
  imm_t      imm;
  reg_addr_t waddr, raddr1, raddr2;
  logic      wren, rden1, rden2, lui, jal, jalr, branch, load, store, ebreak, valid;
  alu_op_t   alu_op;
  bcu_op_t   bcu_op;
  lsu_op_t   lsu_op;

  instr_t    words [0:N_WORDS-1];
  addr_t     exp_pc [0:31];
  logic      exp_req [0:31];   // fetch_req_o during the issue cycle
  logic      exp_valid [0:31];
  reg_addr_t exp_waddr [0:31];
  logic      exp_wren [0:31];
  imm_t      exp_imm [0:31];
  logic      exp_imm_chk [0:31];
  alu_op_t   exp_alu [0:31];
  logic [6:0] exp_flags [0:31];  // lui, jal, jalr, branch, load, store, ebreak
  logic      exp_rvc [0:31];
  logic [1:0] exp_rden [0:31];
  reg_addr_t exp_raddr1 [0:31];
  reg_addr_t exp_raddr2 [0:31];
  logic [3:0] exp_ops [0:31];    // bcu_op, lsu_op

  int n_exp = 0;
  int exp_idx = 0;
  int word_idx = 0;
  int cycle_count = 0;
  int tail_count = 0;
  int error_count = 0;
  int beat_errs = 0;
  int pass_count = 0;
  int fail_count = 0;
  logic take, prev_req, stop, timed_out;

  rv_front_top #(.RESET_VECTOR(RESET_VECTOR)) dut (
    .clock_i(clock), .rst_i(rst), .fetch_valid_i(fetch_valid), .fetch_word_i(fetch_word),
    .fetch_req_o(fetch_req), .out_valid_o(out_valid), .pc_o(pc), .compressed_o(compressed),
    .imm_o(imm), .waddr_o(waddr), .raddr1_o(raddr1), .raddr2_o(raddr2),
    .wren_o(wren), .rden1_o(rden1), .rden2_o(rden2), .lui_o(lui), .jal_o(jal),
    .jalr_o(jalr), .branch_o(branch), .load_o(load), .store_o(store), .ebreak_o(ebreak),
    .valid_o(valid), .alu_op_o(alu_op), .bcu_op_o(bcu_op), .lsu_op_o(lsu_op)
  );

  always #5 clock = ~clock;

  task automatic add_expect(input addr_t p, input logic req, input logic v,
                            input reg_addr_t wa, input logic we, input imm_t im,
                            input logic im_chk, input alu_op_t alu, input logic [6:0] fl,
                            input logic rvc, input logic [1:0] re, input reg_addr_t ra1,
                            input reg_addr_t ra2, input logic [3:0] ops);
    exp_pc[n_exp] = p;
    exp_req[n_exp] = req;
    exp_valid[n_exp] = v;
    exp_waddr[n_exp] = wa;
    exp_wren[n_exp] = we;
    exp_imm[n_exp] = im;
    exp_imm_chk[n_exp] = im_chk;
    exp_alu[n_exp] = alu;
    exp_flags[n_exp] = fl;
    exp_rvc[n_exp] = rvc;
    exp_rden[n_exp] = re;
    exp_raddr1[n_exp] = ra1;
    exp_raddr2[n_exp] = ra2;
    exp_ops[n_exp] = ops;
    n_exp++;
  endtask

  task automatic field_error(input int idx, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("ERR %0t: test %0d field %s got %h expected %h", $time, idx, name, got, exp);
    error_count++;
    beat_errs++;
  endtask

  task automatic check_beat(input int i, input logic req);
    beat_errs = 0;
    if (pc !== exp_pc[i]) field_error(i, "pc", pc, exp_pc[i]);
    if (req !== exp_req[i]) field_error(i, "fetch_req", req, exp_req[i]);
    if (valid !== exp_valid[i]) field_error(i, "valid", valid, exp_valid[i]);
    if (wren !== exp_wren[i]) field_error(i, "wren", wren, exp_wren[i]);
    if (compressed !== exp_rvc[i]) field_error(i, "compressed", compressed, exp_rvc[i]);
    if (exp_valid[i]) begin
      if (exp_wren[i] && waddr !== exp_waddr[i]) field_error(i, "waddr", waddr, exp_waddr[i]);
      if (exp_imm_chk[i] && imm !== exp_imm[i]) field_error(i, "imm", imm, exp_imm[i]);
      if (alu_op !== exp_alu[i]) field_error(i, "alu_op", alu_op, exp_alu[i]);
      if ({lui, jal, jalr, branch, load, store, ebreak} !== exp_flags[i]) begin
        field_error(i, "flags", {lui, jal, jalr, branch, load, store, ebreak}, exp_flags[i]);
      end
      if ({rden1, rden2} !== exp_rden[i]) field_error(i, "rden", {rden1, rden2}, exp_rden[i]);
      if (exp_rden[i][1] && raddr1 !== exp_raddr1[i]) begin
        field_error(i, "raddr1", raddr1, exp_raddr1[i]);
      end
      if (exp_rden[i][0] && raddr2 !== exp_raddr2[i]) begin
        field_error(i, "raddr2", raddr2, exp_raddr2[i]);
      end
      if ({bcu_op, lsu_op} !== exp_ops[i]) field_error(i, "bcu/lsu op", {bcu_op, lsu_op}, exp_ops[i]);
    end
    if (beat_errs == 0) pass_count++;
    else fail_count++;
    $display("test %0d pc %h: %s", i, exp_pc[i], (beat_errs == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    clock = 1'b0;
    rst = 1'b1;
    fetch_valid = 1'b0;
    fetch_word = '0;
    take = 1'b0;
    prev_req = 1'b0;
    stop = 1'b0;
    timed_out = 1'b0;
    void'($urandom(69));

    // Aligned RV32 words, then compressed pairs and a straddling xori
    words[0]  = 32'h00A0_0293;  // addi x5, x0, 10
    words[1]  = 32'h4072_8333;  // sub x6, x5, x7
    words[2]  = 32'h00C1_2403;  // lw x8, 12(x2)
    words[3]  = 32'h0091_2423;  // sw x9, 8(x2)
    words[4]  = 32'hFE20_8CE3;  // beq x1, x2, -8
    words[5]  = 32'h1234_5537;  // lui x10, 0x12345
    words[6]  = 32'h0100_00EF;  // jal x1, 16
    words[7]  = 32'hC60C_4144;  // c.sw x11,8(x12) | c.lw x9,4(x10)
    words[8]  = 32'h4693_5675;  // xori low half | c.li x12,-3
    words[9]  = 32'h6105_07F6;  // c.addi16sp 32 | xori high half
    words[10] = 32'h8282_2021;  // c.jr x5 | c.jal 8
    words[11] = 32'h9002_873E;  // c.ebreak | c.mv x14,x15
    words[12] = 32'h808D_0800;  // c.srli x9,3 | c.addi4spn x8,16
    words[13] = 32'hE299_8D6D;  // c.bnez x13,6 | c.and x10,x11
    words[14] = 32'hC222_47B2;  // c.swsp x8,4 | c.lwsp x15,12
    words[15] = 32'h8000_0004;  // reserved c0 funct3 | addi4spn zero imm
    words[16] = 32'h0000_0097;  // auipc, outside the subset
    words[17] = 32'h0010_0073;  // ebreak

    add_expect(RESET_VECTOR + 'h00, 1, 1, 5'd5,  1, 32'd10, 1, 8'h01, 7'b0000000,
               0, 2'b10, 5'd0,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h04, 1, 1, 5'd6,  1, 32'd0,  1, 8'h02, 7'b0000000,
               0, 2'b11, 5'd5,  5'd7,  4'b0000);
    add_expect(RESET_VECTOR + 'h08, 1, 1, 5'd8,  1, 32'd12, 1, 8'h00, 7'b0000100,
               0, 2'b10, 5'd2,  5'd0,  4'b0001);
    add_expect(RESET_VECTOR + 'h0C, 1, 1, 5'd0,  0, 32'd8,  1, 8'h00, 7'b0000010,
               0, 2'b11, 5'd2,  5'd9,  4'b0010);
    add_expect(RESET_VECTOR + 'h10, 1, 1, 5'd0,  0, -32'sd8, 1, 8'h00, 7'b0001000,
               0, 2'b11, 5'd1,  5'd2,  4'b0100);
    add_expect(RESET_VECTOR + 'h14, 1, 1, 5'd10, 1, 32'h1234_5000, 1, 8'h00, 7'b1000000,
               0, 2'b00, 5'd0,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h18, 1, 1, 5'd1,  1, 32'd16, 1, 8'h00, 7'b0100000,
               0, 2'b00, 5'd0,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h1C, 1, 1, 5'd9,  1, 32'd4,  1, 8'h00, 7'b0000100,
               1, 2'b10, 5'd10, 5'd0,  4'b0001);
    add_expect(RESET_VECTOR + 'h1E, 0, 1, 5'd0,  0, 32'd8,  1, 8'h00, 7'b0000010,
               1, 2'b11, 5'd12, 5'd11, 4'b0010);
    add_expect(RESET_VECTOR + 'h20, 1, 1, 5'd12, 1, -32'sd3, 1, 8'h01, 7'b0000000,
               1, 2'b00, 5'd0,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h22, 1, 1, 5'd13, 1, 32'h7F, 1, 8'h80, 7'b0000000,
               0, 2'b10, 5'd12, 5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h26, 0, 1, 5'd2,  1, 32'd32, 1, 8'h01, 7'b0000000,
               1, 2'b10, 5'd2,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h28, 1, 1, 5'd1,  1, 32'd8,  1, 8'h00, 7'b0100000,
               1, 2'b00, 5'd0,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h2A, 0, 1, 5'd0,  0, 32'd0,  1, 8'h00, 7'b0010000,
               1, 2'b10, 5'd5,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h2C, 1, 1, 5'd14, 1, 32'd0,  1, 8'h01, 7'b0000000,
               1, 2'b01, 5'd0,  5'd15, 4'b0000);
    add_expect(RESET_VECTOR + 'h2E, 0, 1, 5'd0,  0, 32'd0,  1, 8'h00, 7'b0000001,
               1, 2'b00, 5'd0,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h30, 1, 1, 5'd8,  1, 32'd16, 1, 8'h01, 7'b0000000,
               1, 2'b10, 5'd2,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h32, 0, 1, 5'd9,  1, 32'd3,  1, 8'h08, 7'b0000000,
               1, 2'b10, 5'd9,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h34, 1, 1, 5'd10, 1, 32'd0,  0, 8'h20, 7'b0000000,
               1, 2'b11, 5'd10, 5'd11, 4'b0000);
    add_expect(RESET_VECTOR + 'h36, 0, 1, 5'd0,  0, 32'd6,  1, 8'h00, 7'b0001000,
               1, 2'b11, 5'd13, 5'd0,  4'b1000);
    add_expect(RESET_VECTOR + 'h38, 1, 1, 5'd15, 1, 32'd12, 1, 8'h00, 7'b0000100,
               1, 2'b10, 5'd2,  5'd0,  4'b0001);
    add_expect(RESET_VECTOR + 'h3A, 0, 1, 5'd0,  0, 32'd4,  1, 8'h00, 7'b0000010,
               1, 2'b11, 5'd2,  5'd8,  4'b0010);
    add_expect(RESET_VECTOR + 'h3C, 1, 0, 5'd0,  0, 32'd0,  0, 8'h00, 7'b0000000,
               1, 2'b00, 5'd0,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h3E, 0, 0, 5'd0,  0, 32'd0,  0, 8'h00, 7'b0000000,
               1, 2'b00, 5'd0,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h40, 1, 0, 5'd0,  0, 32'd0,  0, 8'h00, 7'b0000000,
               0, 2'b00, 5'd0,  5'd0,  4'b0000);
    add_expect(RESET_VECTOR + 'h44, 1, 1, 5'd0,  0, 32'd0,  1, 8'h00, 7'b0000001,
               0, 2'b00, 5'd0,  5'd0,  4'b0000);

    repeat (RESET_CYCLES) @(negedge clock);
    rst = 1'b0;
    if (fetch_req !== 1'b1 || out_valid !== 1'b0) begin
      $display("ERR %0t: after reset fetch_req %b out_valid %b", $time, fetch_req, out_valid);
      error_count++;
      fail_count++;
      $display("test reset: FAILED");
    end else begin
      pass_count++;
      $display("test reset: ok");
    end

    while (!stop) begin
      prev_req = fetch_req;
      // Memory model with random gaps
      if (fetch_req && word_idx < N_WORDS && ($urandom % 4) != 0) begin
        fetch_valid = 1'b1;
        fetch_word = words[word_idx];
      end else begin
        fetch_valid = 1'b0;
        fetch_word = '0;
      end
      take = fetch_valid && fetch_req;
      @(negedge clock);
      cycle_count++;
      if (take) word_idx++;
      if (out_valid) begin
        if (exp_idx < n_exp) begin
          check_beat(exp_idx, prev_req);
          exp_idx++;
        end else begin
          $display("ERR %0t: extra output beat with pc %h", $time, pc);
          error_count++;
        end
      end
      if (exp_idx == n_exp) tail_count++;
      if (tail_count == TAIL_CYCLES) stop = 1'b1;
      if (cycle_count >= CYCLE_LIMIT && !stop) begin
        $display("Timeout: only %0d of %0d instructions came out after %0d cycles",
                 exp_idx, n_exp, cycle_count);
        timed_out = 1'b1;
        stop = 1'b1;
      end
    end

    $display("tests run %0d of %0d, passed %0d, failed %0d, errors %0d",
             pass_count + fail_count, n_exp + 1, pass_count, fail_count, error_count);
    if (timed_out || fail_count != 0 || error_count != 0) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  end

endmodule

// ==== hw/rv_front_top.sv ====
`timescale 1ns/1ps

module rv_front_top #(
  parameter rv_front_pkg::addr_t RESET_VECTOR = 32'h0000_0000
) (
  input  logic                    clock_i,
  input  logic                    rst_i,
  input  logic                    fetch_valid_i,
  input  rv_front_pkg::instr_t    fetch_word_i,
  output logic                    fetch_req_o,
  output logic                    out_valid_o,
  output rv_front_pkg::addr_t     pc_o,
  output logic                    compressed_o,
  output rv_front_pkg::imm_t      imm_o,
  output rv_front_pkg::reg_addr_t waddr_o, raddr1_o, raddr2_o,
  output logic                    wren_o, rden1_o, rden2_o,
  output logic                    lui_o, jal_o, jalr_o, branch_o,
  output logic                    load_o, store_o, ebreak_o, valid_o,
  output rv_front_pkg::alu_op_t   alu_op_o,
  output rv_front_pkg::bcu_op_t   bcu_op_o,
  output rv_front_pkg::lsu_op_t   lsu_op_o
);
  import rv_front_pkg::*;

  logic      issue, issue_compressed;
  instr_t    issue_instr;
  addr_t     pc;
  imm_t      c_imm, w_imm;
  reg_addr_t c_waddr, c_raddr1, c_raddr2, w_waddr, w_raddr1, w_raddr2;
  logic      c_wren, c_rden1, c_rden2, c_lui, c_jal, c_jalr, c_branch;
  logic      c_load, c_store, c_ebreak, c_valid;
  logic      w_wren, w_rden1, w_rden2, w_lui, w_jal, w_jalr, w_branch;
  logic      w_load, w_store, w_ebreak, w_valid;
  alu_op_t   c_alu_op, w_alu_op;
  bcu_op_t   c_bcu_op, w_bcu_op;
  lsu_op_t   c_lsu_op, w_lsu_op;

  fetch_align_fsm u_align (
    .clock_i(clock_i), .rst_i(rst_i),
    .fetch_valid_i(fetch_valid_i), .fetch_word_i(fetch_word_i), .fetch_req_o(fetch_req_o),
    .issue_o(issue), .issue_instr_o(issue_instr), .issue_compressed_o(issue_compressed)
  );

  pc_counter #(.RESET_VECTOR(RESET_VECTOR)) u_pc (
    .clock_i(clock_i), .rst_i(rst_i),
    .issue_i(issue), .issue_compressed_i(issue_compressed), .pc_o(pc)
  );

  rvc_decode u_rvc (
    .instr_i(issue_instr[15:0]), .imm_o(c_imm),
    .waddr_o(c_waddr), .raddr1_o(c_raddr1), .raddr2_o(c_raddr2),
    .wren_o(c_wren), .rden1_o(c_rden1), .rden2_o(c_rden2), .lui_o(c_lui),
    .jal_o(c_jal), .jalr_o(c_jalr), .branch_o(c_branch), .load_o(c_load),
    .store_o(c_store), .ebreak_o(c_ebreak), .valid_o(c_valid),
    .alu_op_o(c_alu_op), .bcu_op_o(c_bcu_op), .lsu_op_o(c_lsu_op)
  );

  rv32_decode u_rv32 (
    .instr_i(issue_instr), .imm_o(w_imm),
    .waddr_o(w_waddr), .raddr1_o(w_raddr1), .raddr2_o(w_raddr2),
    .wren_o(w_wren), .rden1_o(w_rden1), .rden2_o(w_rden2), .lui_o(w_lui),
    .jal_o(w_jal), .jalr_o(w_jalr), .branch_o(w_branch), .load_o(w_load),
    .store_o(w_store), .ebreak_o(w_ebreak), .valid_o(w_valid),
    .alu_op_o(w_alu_op), .bcu_op_o(w_bcu_op), .lsu_op_o(w_lsu_op)
  );

  decode_out_reg u_out (
    .clock_i(clock_i), .rst_i(rst_i), .issue_i(issue),
    .compressed_i(issue_compressed), .pc_i(pc),
    .c_imm_i(c_imm), .w_imm_i(w_imm), .c_waddr_i(c_waddr), .w_waddr_i(w_waddr),
    .c_raddr1_i(c_raddr1), .w_raddr1_i(w_raddr1),
    .c_raddr2_i(c_raddr2), .w_raddr2_i(w_raddr2),
    .c_wren_i(c_wren), .c_rden1_i(c_rden1), .c_rden2_i(c_rden2), .c_lui_i(c_lui),
    .c_jal_i(c_jal), .c_jalr_i(c_jalr), .c_branch_i(c_branch), .c_load_i(c_load),
    .c_store_i(c_store), .c_ebreak_i(c_ebreak), .c_valid_i(c_valid),
    .w_wren_i(w_wren), .w_rden1_i(w_rden1), .w_rden2_i(w_rden2), .w_lui_i(w_lui),
    .w_jal_i(w_jal), .w_jalr_i(w_jalr), .w_branch_i(w_branch), .w_load_i(w_load),
    .w_store_i(w_store), .w_ebreak_i(w_ebreak), .w_valid_i(w_valid),
    .c_alu_op_i(c_alu_op), .w_alu_op_i(w_alu_op), .c_bcu_op_i(c_bcu_op),
    .w_bcu_op_i(w_bcu_op), .c_lsu_op_i(c_lsu_op), .w_lsu_op_i(w_lsu_op),
    .out_valid_o(out_valid_o), .pc_o(pc_o), .compressed_o(compressed_o), .imm_o(imm_o),
    .waddr_o(waddr_o), .raddr1_o(raddr1_o), .raddr2_o(raddr2_o),
    .wren_o(wren_o), .rden1_o(rden1_o), .rden2_o(rden2_o), .lui_o(lui_o),
    .jal_o(jal_o), .jalr_o(jalr_o), .branch_o(branch_o), .load_o(load_o),
    .store_o(store_o), .ebreak_o(ebreak_o), .valid_o(valid_o),
    .alu_op_o(alu_op_o), .bcu_op_o(bcu_op_o), .lsu_op_o(lsu_op_o)
  );

endmodule

// ==== hw/decode_out_reg.sv ====
`timescale 1ns/1ps

module decode_out_reg (
  input  logic                    clock_i,
  input  logic                    rst_i,
  input  logic                    issue_i,
  input  logic                    compressed_i,
  input  rv_front_pkg::addr_t     pc_i,
  input  rv_front_pkg::imm_t      c_imm_i, w_imm_i,
  input  rv_front_pkg::reg_addr_t c_waddr_i, w_waddr_i,
  input  rv_front_pkg::reg_addr_t c_raddr1_i, w_raddr1_i, c_raddr2_i, w_raddr2_i,
  input  logic                    c_wren_i, c_rden1_i, c_rden2_i, c_lui_i,
  input  logic                    c_jal_i, c_jalr_i, c_branch_i, c_load_i,
  input  logic                    c_store_i, c_ebreak_i, c_valid_i,
  input  logic                    w_wren_i, w_rden1_i, w_rden2_i, w_lui_i,
  input  logic                    w_jal_i, w_jalr_i, w_branch_i, w_load_i,
  input  logic                    w_store_i, w_ebreak_i, w_valid_i,
  input  rv_front_pkg::alu_op_t   c_alu_op_i, w_alu_op_i,
  input  rv_front_pkg::bcu_op_t   c_bcu_op_i, w_bcu_op_i,
  input  rv_front_pkg::lsu_op_t   c_lsu_op_i, w_lsu_op_i,
  output logic                    out_valid_o,
  output rv_front_pkg::addr_t     pc_o,
  output logic                    compressed_o,
  output rv_front_pkg::imm_t      imm_o,
  output rv_front_pkg::reg_addr_t waddr_o, raddr1_o, raddr2_o,
  output logic                    wren_o, rden1_o, rden2_o,
  output logic                    lui_o, jal_o, jalr_o, branch_o,
  output logic                    load_o, store_o, ebreak_o, valid_o,
  output rv_front_pkg::alu_op_t   alu_op_o,
  output rv_front_pkg::bcu_op_t   bcu_op_o,
  output rv_front_pkg::lsu_op_t   lsu_op_o
);

  logic [10:0] c_flags;
  logic [10:0] w_flags;

  assign c_flags = {c_wren_i, c_rden1_i, c_rden2_i, c_lui_i, c_jal_i, c_jalr_i,
                    c_branch_i, c_load_i, c_store_i, c_ebreak_i, c_valid_i};
  assign w_flags = {w_wren_i, w_rden1_i, w_rden2_i, w_lui_i, w_jal_i, w_jalr_i,
                    w_branch_i, w_load_i, w_store_i, w_ebreak_i, w_valid_i};

  // Enables and flags drop whenever nothing issues
  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
      {wren_o, rden1_o, rden2_o, lui_o, jal_o, jalr_o,
       branch_o, load_o, store_o, ebreak_o, valid_o} <= '0;
    end else begin
      out_valid_o <= issue_i;
      {wren_o, rden1_o, rden2_o, lui_o, jal_o, jalr_o,
       branch_o, load_o, store_o, ebreak_o, valid_o} <=
        {11{issue_i}} & (compressed_i ? c_flags : w_flags);
    end
  end

  always_ff @(posedge clock_i) begin
    if (issue_i) begin
      pc_o <= pc_i;
      compressed_o <= compressed_i;  // Size of the issued instruction
      imm_o <= compressed_i ? c_imm_i : w_imm_i;
      waddr_o <= compressed_i ? c_waddr_i : w_waddr_i;
      raddr1_o <= compressed_i ? c_raddr1_i : w_raddr1_i;
      raddr2_o <= compressed_i ? c_raddr2_i : w_raddr2_i;
      alu_op_o <= compressed_i ? c_alu_op_i : w_alu_op_i;
      bcu_op_o <= compressed_i ? c_bcu_op_i : w_bcu_op_i;
      lsu_op_o <= compressed_i ? c_lsu_op_i : w_lsu_op_i;
    end
  end

endmodule

// ==== hw/rv32_decode.sv ====
`timescale 1ns/1ps

module rv32_decode (
  input  rv_front_pkg::instr_t    instr_i,
  output rv_front_pkg::imm_t      imm_o,
  output rv_front_pkg::reg_addr_t waddr_o,
  output rv_front_pkg::reg_addr_t raddr1_o,
  output rv_front_pkg::reg_addr_t raddr2_o,
  output logic                    wren_o, rden1_o, rden2_o,
  output logic                    lui_o, jal_o, jalr_o, branch_o,
  output logic                    load_o, store_o, ebreak_o, valid_o,
  output rv_front_pkg::alu_op_t   alu_op_o,
  output rv_front_pkg::bcu_op_t   bcu_op_o,
  output rv_front_pkg::lsu_op_t   lsu_op_o
);
  import rv_front_pkg::*;

  imm_t       imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_reg;
  logic       f7_checked;

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign is_reg = opcode == op_reg;
  assign f7_checked = is_reg || (funct3[1:0] == 2'b01);  // Register ops and shifts

  always_comb begin
    imm_o = '0;
    waddr_o = instr_i[11:7];
    raddr1_o = instr_i[19:15];
    raddr2_o = instr_i[24:20];
    {wren_o, rden1_o, rden2_o} = 3'b000;
    {lui_o, jal_o, jalr_o, branch_o, load_o, store_o, ebreak_o} = 7'b0;
    valid_o = 1'b1;
    alu_op_o = '0;
    bcu_op_o = '0;
    lsu_op_o = '0;
    case (opcode)
      op_lui: begin
        imm_o = imm_u;
        {wren_o, lui_o} = 2'b11;
      end
      op_jal: begin
        imm_o = imm_j;
        {wren_o, jal_o} = 2'b11;
      end
      op_jalr: begin
        imm_o = imm_i;
        {wren_o, rden1_o, jalr_o} = 3'b111;
        valid_o = funct3 == 3'b000;
      end
      op_branch: begin
        imm_o = imm_b;
        {rden1_o, rden2_o, branch_o} = 3'b111;
        bcu_op_o[funct3[0] ? bcu_bne : bcu_beq] = 1'b1;
        valid_o = funct3[2:1] == 2'b00;
      end
      op_load: begin
        imm_o = imm_i;
        {wren_o, rden1_o, load_o} = 3'b111;
        lsu_op_o[lsu_lw] = 1'b1;
        valid_o = funct3 == 3'b010;
      end
      op_store: begin
        imm_o = imm_s;
        {rden1_o, rden2_o, store_o} = 3'b111;
        lsu_op_o[lsu_sw] = 1'b1;
        valid_o = funct3 == 3'b010;
      end
      op_imm, op_reg: begin
        if (!is_reg) imm_o = imm_i;
        {wren_o, rden1_o, rden2_o} = {2'b11, is_reg};
        case (funct3)
          3'b000: alu_op_o[(is_reg && instr_i[30]) ? alu_sub : alu_add] = 1'b1;
          3'b001: alu_op_o[alu_sll] = 1'b1;
          3'b100: alu_op_o[alu_xor] = 1'b1;
          3'b101: alu_op_o[instr_i[30] ? alu_sra : alu_srl] = 1'b1;
          3'b110: alu_op_o[alu_or] = 1'b1;
          3'b111: alu_op_o[alu_and] = 1'b1;
          default: valid_o = 1'b0;  // slt and sltu
        endcase
        if (f7_checked && funct7 != 7'h00 && funct7 != 7'h20) valid_o = 1'b0;
        if (f7_checked && funct7 == 7'h20 && funct3 != 3'b000 && funct3 != 3'b101) begin
          valid_o = 1'b0;
        end
      end
      op_system: begin
        ebreak_o = instr_i == 32'h0010_0073;
        valid_o = ebreak_o;
      end
      default: valid_o = 1'b0;
    endcase
    wren_o = wren_o & valid_o;
  end

endmodule

// ==== hw/rvc_decode.sv ====
`timescale 1ns/1ps

module rvc_decode (
  input  rv_front_pkg::half_t     instr_i,
  output rv_front_pkg::imm_t      imm_o,
  output rv_front_pkg::reg_addr_t waddr_o,
  output rv_front_pkg::reg_addr_t raddr1_o,
  output rv_front_pkg::reg_addr_t raddr2_o,
  output logic                    wren_o, rden1_o, rden2_o,
  output logic                    lui_o, jal_o, jalr_o, branch_o,
  output logic                    load_o, store_o, ebreak_o, valid_o,
  output rv_front_pkg::alu_op_t   alu_op_o,
  output rv_front_pkg::bcu_op_t   bcu_op_o,
  output rv_front_pkg::lsu_op_t   lsu_op_o
);
  import rv_front_pkg::*;

  imm_t      imm_lwsp, imm_swsp, imm_lsw, imm_w;
  imm_t      imm_i, imm_u, imm_p, imm_j, imm_b;
  reg_addr_t rs1_p;
  reg_addr_t rs2_p;
  logic      rd_nz;
  logic      rs2_nz;

  assign imm_lwsp = {24'b0, instr_i[3:2], instr_i[12], instr_i[6:4], 2'b0};
  assign imm_swsp = {24'b0, instr_i[8:7], instr_i[12:9], 2'b0};
  assign imm_lsw  = {25'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b0};
  assign imm_w    = {22'b0, instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6], 2'b0};
  assign imm_i    = {{26{instr_i[12]}}, instr_i[12], instr_i[6:2]};
  assign imm_u    = {{14{instr_i[12]}}, instr_i[12], instr_i[6:2], 12'b0};
  assign imm_p    = {{22{instr_i[12]}}, instr_i[12], instr_i[4:3], instr_i[5], instr_i[2],
                     instr_i[6], 4'b0};
  assign imm_j    = {{20{instr_i[12]}}, instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                     instr_i[7], instr_i[2], instr_i[11], instr_i[5:3], 1'b0};
  assign imm_b    = {{23{instr_i[12]}}, instr_i[12], instr_i[6:5], instr_i[2],
                     instr_i[11:10], instr_i[4:3], 1'b0};

  assign rs1_p = {2'b01, instr_i[9:7]};  // x8..x15
  assign rs2_p = {2'b01, instr_i[4:2]};
  assign rd_nz = |instr_i[11:7];
  assign rs2_nz = |instr_i[6:2];

  always_comb begin
    imm_o = '0;
    waddr_o = instr_i[11:7];
    raddr1_o = instr_i[11:7];
    raddr2_o = instr_i[6:2];
    {wren_o, rden1_o, rden2_o} = 3'b000;
    {lui_o, jal_o, jalr_o, branch_o, load_o, store_o, ebreak_o} = 7'b0;
    valid_o = 1'b1;
    alu_op_o = '0;
    bcu_op_o = '0;
    lsu_op_o = '0;
    case (instr_i[1:0])
      opcode_c0: begin
        raddr1_o = rs1_p;
        raddr2_o = rs2_p;
        waddr_o = rs2_p;
        case (instr_i[15:13])
          c0_addi4spn: begin
            imm_o = imm_w;
            raddr1_o = 5'd2;
            {wren_o, rden1_o} = 2'b11;
            alu_op_o[alu_add] = 1'b1;
            valid_o = |imm_w;  // Zero immediate is reserved
          end
          c0_lw: begin
            imm_o = imm_lsw;
            {wren_o, rden1_o, load_o} = 3'b111;
            lsu_op_o[lsu_lw] = 1'b1;
          end
          c0_sw: begin
            imm_o = imm_lsw;
            {rden1_o, rden2_o, store_o} = 3'b111;
            lsu_op_o[lsu_sw] = 1'b1;
          end
          default: valid_o = 1'b0;
        endcase
      end
      opcode_c1: begin
        imm_o = imm_i;
        case (instr_i[15:13])
          c1_addi: begin
            {wren_o, rden1_o} = {2{|imm_i}};  // Zero immediate is a hint
            alu_op_o[alu_add] = 1'b1;
          end
          c1_jal: begin
            imm_o = imm_j;
            waddr_o = 5'd1;
            {wren_o, jal_o} = 2'b11;
          end
          c1_li: begin
            wren_o = 1'b1;
            alu_op_o[alu_add] = 1'b1;
          end
          c1_lui: begin
            if (instr_i[11:7] == 5'd2) begin
              imm_o = imm_p;  // addi16sp
              {wren_o, rden1_o} = {2{|imm_p}};
              alu_op_o[alu_add] = 1'b1;
            end else begin
              imm_o = imm_u;
              wren_o = |imm_u;
              lui_o = 1'b1;
            end
          end
          c1_alu: begin
            waddr_o = rs1_p;
            raddr1_o = rs1_p;
            raddr2_o = rs2_p;
            rden1_o = 1'b1;
            case (instr_i[11:10])
              2'b00, 2'b01: begin
                wren_o = rs2_nz;
                valid_o = !instr_i[12];  // shamt[5] reserved on RV32
                alu_op_o[instr_i[10] ? alu_sra : alu_srl] = 1'b1;
              end
              2'b10: begin
                wren_o = 1'b1;
                alu_op_o[alu_and] = 1'b1;
              end
              default: begin
                {wren_o, rden2_o} = 2'b11;
                case ({instr_i[12], instr_i[6:5]})
                  3'b000: alu_op_o[alu_sub] = 1'b1;
                  3'b001: alu_op_o[alu_xor] = 1'b1;
                  3'b010: alu_op_o[alu_or] = 1'b1;
                  3'b011: alu_op_o[alu_and] = 1'b1;
                  default: valid_o = 1'b0;
                endcase
              end
            endcase
          end
          c1_j: begin
            imm_o = imm_j;
            waddr_o = 5'd0;
            jal_o = 1'b1;
          end
          c1_beqz, c1_bnez: begin
            imm_o = imm_b;
            raddr1_o = rs1_p;
            raddr2_o = 5'd0;
            {rden1_o, rden2_o, branch_o} = 3'b111;
            bcu_op_o[instr_i[13] ? bcu_bne : bcu_beq] = 1'b1;
          end
        endcase
      end
      opcode_c2: begin
        case (instr_i[15:13])
          c2_slli: begin
            imm_o = imm_i;
            {wren_o, rden1_o} = {2{rs2_nz}};
            valid_o = !instr_i[12];
            alu_op_o[alu_sll] = 1'b1;
          end
          c2_lwsp: begin
            imm_o = imm_lwsp;
            raddr1_o = 5'd2;
            {wren_o, rden1_o, load_o} = 3'b111;
            lsu_op_o[lsu_lw] = 1'b1;
            valid_o = rd_nz;
          end
          c2_alu: begin
            if (!rs2_nz) begin
              if (instr_i[12] && !rd_nz) begin
                ebreak_o = 1'b1;
              end else begin
                // jr, or jalr linking to x1
                waddr_o = 5'd1;
                {wren_o, rden1_o, jalr_o} = {instr_i[12], 2'b11};
                valid_o = rd_nz;
              end
            end else begin
              // mv reads only rs2, add reads both
              if (!instr_i[12]) raddr1_o = 5'd0;
              {wren_o, rden1_o, rden2_o} = {rd_nz, instr_i[12], 1'b1};
              alu_op_o[alu_add] = 1'b1;
            end
          end
          c2_swsp: begin
            imm_o = imm_swsp;
            raddr1_o = 5'd2;
            {rden1_o, rden2_o, store_o} = 3'b111;
            lsu_op_o[lsu_sw] = 1'b1;
          end
          default: valid_o = 1'b0;
        endcase
      end
      default: valid_o = 1'b0;
    endcase
    wren_o = wren_o & valid_o;
  end

endmodule

// ==== hw/pc_counter.sv ====
`timescale 1ns/1ps

module pc_counter #(
  parameter rv_front_pkg::addr_t RESET_VECTOR = 32'h0000_0000
) (
  input  logic                clock_i,
  input  logic                rst_i,
  input  logic                issue_i,
  input  logic                issue_compressed_i,
  output rv_front_pkg::addr_t pc_o
);
  import rv_front_pkg::*;

  addr_t step;

  assign step = issue_compressed_i ? addr_t'(2) : addr_t'(4);

  // Holds the address of the instruction issuing now
  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      pc_o <= RESET_VECTOR;
    end else if (issue_i) begin
      pc_o <= pc_o + step;
    end
  end

endmodule

// ==== hw/fetch_align_fsm.sv ====
`timescale 1ns/1ps

module fetch_align_fsm (
  input  logic                 clock_i,
  input  logic                 rst_i,
  input  logic                 fetch_valid_i,
  input  rv_front_pkg::instr_t fetch_word_i,
  output logic                 fetch_req_o,
  output logic                 issue_o,
  output rv_front_pkg::instr_t issue_instr_o,
  output logic                 issue_compressed_o
);
  import rv_front_pkg::*;

  align_state_t state;
  align_state_t state_next;
  half_t        pending;
  half_t        pending_next;
  logic         pending_rvc;
  logic         low_rvc;

  assign pending_rvc = pending[1:0] != 2'b11;
  assign low_rvc = fetch_word_i[1:0] != 2'b11;

  always_comb begin
    fetch_req_o = 1'b1;
    issue_o = 1'b0;
    issue_instr_o = fetch_word_i;
    issue_compressed_o = 1'b0;
    state_next = state;
    pending_next = pending;
    case (state)
      st_empty: begin
        if (fetch_valid_i) begin
          issue_o = 1'b1;
          if (low_rvc) begin
            issue_instr_o = {16'b0, fetch_word_i[15:0]};
            issue_compressed_o = 1'b1;
            pending_next = fetch_word_i[31:16];
            state_next = st_half;
          end
        end
      end
      st_half: begin
        if (pending_rvc) begin
          fetch_req_o = 1'b0;  // No fetch needed this cycle
          issue_o = 1'b1;
          issue_instr_o = {16'b0, pending};
          issue_compressed_o = 1'b1;
          state_next = st_empty;
        end else if (fetch_valid_i) begin
          // Straddling instruction, new upper half stays pending
          issue_o = 1'b1;
          issue_instr_o = {fetch_word_i[15:0], pending};
          pending_next = fetch_word_i[31:16];
        end
      end
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      state <= st_empty;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock_i) begin
    pending <= pending_next;
  end

endmodule

// ==== hw/rv_front_pkg.sv ====
package rv_front_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [15:0] half_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] imm_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  alu_op_t;
  typedef logic [1:0]  bcu_op_t;
  typedef logic [1:0]  lsu_op_t;

  typedef enum logic {
    st_empty,
    st_half   // Upper halfword of last word still pending
  } align_state_t;

  // One-hot bit positions
  localparam int alu_add = 0;
  localparam int alu_sub = 1;
  localparam int alu_sll = 2;
  localparam int alu_srl = 3;
  localparam int alu_sra = 4;
  localparam int alu_and = 5;
  localparam int alu_or  = 6;
  localparam int alu_xor = 7;
  localparam int bcu_beq = 0;
  localparam int bcu_bne = 1;
  localparam int lsu_lw  = 0;
  localparam int lsu_sw  = 1;

  // Compressed quadrants
  localparam logic [1:0] opcode_c0 = 2'b00;
  localparam logic [1:0] opcode_c1 = 2'b01;
  localparam logic [1:0] opcode_c2 = 2'b10;

  localparam logic [2:0] c0_addi4spn = 3'b000;
  localparam logic [2:0] c0_lw       = 3'b010;
  localparam logic [2:0] c0_sw       = 3'b110;
  localparam logic [2:0] c1_addi     = 3'b000;
  localparam logic [2:0] c1_jal      = 3'b001;
  localparam logic [2:0] c1_li       = 3'b010;
  localparam logic [2:0] c1_lui      = 3'b011;
  localparam logic [2:0] c1_alu      = 3'b100;
  localparam logic [2:0] c1_j        = 3'b101;
  localparam logic [2:0] c1_beqz     = 3'b110;
  localparam logic [2:0] c1_bnez     = 3'b111;
  localparam logic [2:0] c2_slli     = 3'b000;
  localparam logic [2:0] c2_lwsp     = 3'b010;
  localparam logic [2:0] c2_alu      = 3'b100;
  localparam logic [2:0] c2_swsp     = 3'b110;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

endpackage
